//--- common/cmprs_pkg.sv
// shared definitions of the macroblock scheduling front end
// buffer geometry, page pointer and pixel types
// tile width and start pipeline stage enums, tile width helper
`default_nettype none

package cmprs_pkg;

    localparam int num_pages  = 4;   // pages in the tile buffer
    localparam int tile_rows  = 16;  // rows in a tile and in a macroblock
    localparam int max_tile_w = 128; // widest page, 16 rows of it fill the 11-bit in-page address
    localparam int mb_stages  = 9;   // length of the pacer start pipeline

    typedef logic [2:0] page_ptr_t;  // bit 2 tells a full ring from an empty one
    typedef logic [7:0] pix_t;       // one monochrome pixel

    typedef enum logic [1:0] {
        tw16,
        tw32,
        tw64,
        tw128
    } tile_w_e;

    typedef enum logic [3:0] {
        calc_row,     // step the column and row counters
        calc_x,       // left x in the page, first and last flags
        calc_last,    // x of the rightmost macroblock column
        calc_need,    // newest page the macroblock reads
        wait_buf,     // hold here until that page is loaded
        issue,        // hand the macroblock to the reader
        calc_next,    // left x of the following macroblock
        calc_release, // pages this macroblock leaves behind
        advance       // move the oldest page pointer
    } mb_stage_e;

    // log2 of the tile width in bytes
    function automatic logic [2:0] tile_shift(tile_w_e tw);
        return 3'd4 + {1'b0, tw};
    endfunction

endpackage

`default_nettype wire

//--- common/cmprs_ifs.sv
// page_wr_if, the loader to tile buffer write port
// mb_ctrl_if, the macroblock start command from pacer to reader
`timescale 1ns/1ps
`default_nettype none

interface page_wr_if #(
    parameter int data_w  = 8,
    parameter int page_aw = 11
);
    logic               wr_en;   // one byte written in every cycle this is high
    logic [1:0]         wr_page; // page in the ring
    logic [page_aw-1:0] wr_addr; // tile row and column inside the page
    logic [data_w-1:0]  wr_data;

    modport master (output wr_en, output wr_page, output wr_addr, output wr_data);
    modport slave  (input wr_en, input wr_page, input wr_addr, input wr_data);
endinterface

interface mb_ctrl_if;
    logic       mb_start;     // single cycle, the other fields are valid with it
    logic [1:0] start_page;   // oldest page the macroblock reads
    logic [6:0] macroblock_x; // left pixel x inside start_page
    logic       first_mb;
    logic       last_mb;

    modport master (
        output mb_start,
        output start_page,
        output macroblock_x,
        output first_mb,
        output last_mb
    );
    modport slave (
        input mb_start,
        input start_page,
        input macroblock_x,
        input first_mb,
        input last_mb
    );
endinterface

`default_nettype wire

//--- rtl/page_loader.sv
// page_loader
// writes the incoming tile bytes into the page ring row by row
// flags each completed page and keeps the free page count for back-pressure
`timescale 1ns/1ps
`default_nettype none

module page_loader #(
    parameter int data_w  = 8,
    parameter int page_aw = 11
) (
    input  wire logic               xclk,
    input  wire logic               reset_page_rd,
    input  wire logic               in_valid,
    input  wire cmprs_pkg::pix_t    in_data,
    output logic                    in_room,
    input  wire cmprs_pkg::tile_w_e tile_width,
    input  wire logic               release_pulse,
    input  wire logic [1:0]         release_cnt,
    output logic                    page_ready,
    page_wr_if.master               wr
);
    import cmprs_pkg::*;

    logic [6:0] col;      // byte column inside the tile row
    logic [3:0] row;      // tile row, wraps after the last one
    logic [6:0] col_last; // last column for the selected width
    page_ptr_t  wr_ptr;   // page being filled
    logic [2:0] free_cnt; // pages not holding unreleased data
    logic       accept;
    logic       page_end;

    assign col_last = 7'((8'd1 << tile_shift(tile_width)) - 8'd1);
    assign accept   = in_valid && in_room;
    assign page_end = accept && (col == col_last) && (row == 4'(tile_rows - 1));
    assign in_room  = (free_cnt != 3'd0); // drops once all pages wait for release

    always_ff @(posedge xclk) begin
        if (reset_page_rd) begin
            col        <= '0;
            row        <= '0;
            wr_ptr     <= '0;
            free_cnt   <= 3'(num_pages);
            page_ready <= 1'b0;
            wr.wr_en   <= 1'b0;
        end else begin
            page_ready <= page_end; // same cycle as the write of the last byte
            wr.wr_en   <= accept;
            if (accept) begin
                col <= (col == col_last) ? 7'd0 : col + 7'd1;
                if (col == col_last) row <= row + 4'd1;
            end
            if (page_end) wr_ptr <= wr_ptr + 3'd1;
            free_cnt <= free_cnt + (release_pulse ? {1'b0, release_cnt} : 3'd0)
                        - {2'b0, page_end}; // release and fill may meet in one cycle
        end
    end

    // row in the upper bits, so the layout does not depend on the tile width
    always_ff @(posedge xclk) begin
        wr.wr_page <= wr_ptr[1:0];
        wr.wr_addr <= page_aw'({row, col});
        wr.wr_data <= data_w'(in_data);
    end

    a_free_bound: assert property (@(posedge xclk) disable iff (reset_page_rd)
        free_cnt <= 3'(num_pages));

endmodule

`default_nettype wire

//--- tile_buf/tile_page_buf.sv
// tile_page_buf
// four-page byte memory, one write port and one registered read port
`timescale 1ns/1ps
`default_nettype none

module tile_page_buf #(
    parameter int data_w  = 8,
    parameter int page_aw = 11
) (
    input  wire logic               xclk,
    page_wr_if.slave                wr,
    input  wire logic [1:0]         rd_page,
    input  wire logic [page_aw-1:0] rd_addr,
    output logic [data_w-1:0]       rd_data
);
    import cmprs_pkg::*;

    localparam int depth = num_pages * max_tile_w * tile_rows; // every page holds the widest tile

    logic [data_w-1:0] mem [depth];

    always_ff @(posedge xclk) begin
        if (wr.wr_en) mem[{wr.wr_page, wr.wr_addr}] <= wr.wr_data;
        rd_data <= mem[{rd_page, rd_addr}]; // one cycle read latency
    end

endmodule

`default_nettype wire

//--- macroblock/mb_pacer.sv
// mb_pacer
// counts macroblocks across the frame and finds the start page and left x of each
// one-hot start pipeline that waits until every needed page is loaded
// releases the pages passed over at the end of each macroblock, flags frame_done
`timescale 1ns/1ps
`default_nettype none

module mb_pacer (
    input  wire logic               xclk,
    input  wire logic               reset_page_rd,
    input  wire logic               frame_en,
    input  wire logic               frame_go,
    input  wire cmprs_pkg::tile_w_e tile_width,
    input  wire logic [4:0]         left_marg,
    input  wire logic [5:0]         mb_w_m1,
    input  wire logic [4:0]         mb_hper,
    input  wire logic [12:0]        n_blocks_in_row_m1,
    input  wire logic [12:0]        n_block_rows_m1,
    input  wire logic               page_ready,
    input  wire logic               mb_pre_end,
    output logic                    release_pulse,
    output logic [1:0]              release_cnt,
    output logic                    frame_done,
    mb_ctrl_if.master               ctrl
);
    import cmprs_pkg::*;

    logic [mb_stages-1:0] stage; // indexed by mb_stage_e
    logic        frame_en_w;
    logic        frame_en_r;
    logic        frame_run;     // between the first start and the last pre-end
    logic        frame_start_w;
    logic        frame_start_r; // lines up with stage calc_row
    logic        mb_start_w;
    logic        buf_ready;
    logic [12:0] cols_left;     // macroblocks left in the row after this one
    logic [12:0] rows_left;
    logic        first_in_row;
    logic        last_in_row;
    logic        last_row;
    logic        last_mb;
    logic        pre_first;
    logic        first_mb_r;
    logic [6:0]  mbl_x;         // left x inside the start page
    logic [6:0]  x_next;        // left x of the next macroblock in the row
    logic [7:0]  x_last;        // rightmost column, may run into later pages
    logic [7:0]  x_inc;
    logic [7:0]  tw_mask;
    logic [1:0]  adv_tiles;     // pages passed over inside a row
    logic [1:0]  used_pages;    // pages spanned by this macroblock
    logic [1:0]  add_invalid;   // pages this macroblock leaves behind
    page_ptr_t   needed_page;
    page_ptr_t   next_valid;    // first page not loaded yet
    page_ptr_t   next_invalid;  // oldest page still in use
    page_ptr_t   buf_diff;
    logic [8:0]  done_sr;       // pre-end of the last macroblock to frame_done

    assign frame_en_w    = frame_en && frame_go;
    assign last_mb       = last_row && last_in_row;
    assign mb_start_w    = (mb_pre_end && (!last_mb || frame_en_w))
                           || (!frame_run && frame_en_w && !frame_en_r && !(|stage));
    assign frame_start_w = frame_en_w
                           && ((mb_pre_end && last_mb) || (!frame_run && !frame_en_r && !(|stage)));
    assign buf_diff      = needed_page - next_valid;
    assign buf_ready     = buf_diff[2]; // needed page is behind the load pointer
    assign x_inc         = {1'b0, mbl_x} + {3'b0, mb_hper};
    assign tw_mask       = (8'd1 << tile_shift(tile_width)) - 8'd1;
    assign frame_done    = done_sr[8]; // one cycle after the last pixel

    always_ff @(posedge xclk) begin
        if (reset_page_rd || !frame_en) begin // frame_en low aborts at once
            frame_en_r    <= 1'b0;
            frame_run     <= 1'b0;
            frame_start_r <= 1'b0;
            first_in_row  <= 1'b0;
            pre_first     <= 1'b0;
            stage         <= '0;
            done_sr       <= '0;
            ctrl.mb_start <= 1'b0;
            release_pulse <= 1'b0;
        end else begin
            frame_en_r    <= frame_en_w;
            frame_start_r <= frame_start_w;
            if (mb_start_w) frame_run <= 1'b1;
            else if (mb_pre_end && last_mb) frame_run <= 1'b0;
            if (frame_start_r) first_in_row <= 1'b1;
            else if (stage[calc_row]) first_in_row <= last_in_row;
            if (frame_start_r) pre_first <= 1'b1;
            else if (stage[calc_x]) pre_first <= 1'b0;
            if (mb_start_w) stage <= mb_stages'(1);
            else if (!stage[wait_buf] || buf_ready) stage <= stage << 1;
            done_sr       <= {done_sr[7:0], mb_pre_end && last_mb};
            ctrl.mb_start <= stage[issue]; // reader starts right after the previous last read
            release_pulse <= mb_pre_end;
        end
    end

    // pointers survive a frame abort
    always_ff @(posedge xclk) begin
        if (reset_page_rd) begin
            next_valid   <= '0;
            next_invalid <= '0;
        end else begin
            if (page_ready) next_valid <= next_valid + 3'd1;
            if (stage[advance]) next_invalid <= next_invalid + {1'b0, add_invalid};
        end
    end

    always_ff @(posedge xclk) begin
        if (frame_start_r) rows_left <= n_block_rows_m1;
        else if (stage[calc_row] && last_in_row) rows_left <= rows_left - 13'd1;
        if (frame_start_r || (stage[calc_row] && last_in_row)) cols_left <= n_blocks_in_row_m1;
        else if (stage[calc_row]) cols_left <= cols_left - 13'd1;
        if (stage[calc_x]) begin
            last_row    <= (rows_left == 13'd0);
            last_in_row <= (cols_left == 13'd0);
            first_mb_r  <= pre_first;
            mbl_x       <= first_in_row ? {2'b0, left_marg} : x_next;
        end
        if (stage[calc_last]) x_last <= {1'b0, mbl_x} + {2'b0, mb_w_m1};
        if (stage[calc_need]) begin
            needed_page <= next_invalid + page_ptr_t'(x_last >> tile_shift(tile_width));
        end
        if (stage[issue]) begin
            ctrl.start_page   <= next_invalid[1:0];
            ctrl.macroblock_x <= mbl_x;
            ctrl.first_mb     <= first_mb_r;
            ctrl.last_mb      <= last_mb;
        end
        if (stage[calc_next]) begin
            x_next     <= x_inc[6:0] & tw_mask[6:0]; // wrap into the following page
            adv_tiles  <= 2'(x_inc >> tile_shift(tile_width));
            used_pages <= needed_page[1:0] - next_invalid[1:0] + 2'd1;
        end
        // a new macroblock row starts on a fresh tile row
        if (stage[calc_release]) add_invalid <= last_in_row ? used_pages : adv_tiles;
        if (mb_pre_end) release_cnt <= add_invalid;
    end

    // a start must find the pipeline empty, so only one macroblock token is ever in flight
    a_start_idle: assert property (@(posedge xclk) disable iff (reset_page_rd)
        mb_start_w |-> (stage == '0));
    a_need_fits: assert property (@(posedge xclk) disable iff (reset_page_rd)
        stage[wait_buf] |-> (page_ptr_t'(needed_page - next_invalid) < 3'(num_pages)));

endmodule

`default_nettype wire

//--- macroblock/mb_pixel_reader.sv
// mb_pixel_reader
// reads a 16-row macroblock per start command, row by row, across page edges
// emits the pixel stream with first and last flags, and pre-end 8 cycles ahead
`timescale 1ns/1ps
`default_nettype none

module mb_pixel_reader #(
    parameter int data_w  = 8,
    parameter int page_aw = 11
) (
    input  wire logic               xclk,
    input  wire logic               reset_page_rd,
    input  wire cmprs_pkg::tile_w_e tile_width,
    input  wire logic [5:0]         mb_w_m1,
    mb_ctrl_if.slave                ctrl,
    output logic [1:0]              rd_page,
    output logic [page_aw-1:0]      rd_addr,
    input  wire logic [data_w-1:0]  rd_data,
    output logic                    mb_pre_end,
    output logic                    pix_valid,
    output logic [data_w-1:0]       pix_data,
    output logic                    pix_first_mb,
    output logic                    pix_last_mb
);
    import cmprs_pkg::*;

    logic       active;   // read request for (row, col) this cycle
    logic [3:0] row;
    logic [5:0] col;
    logic [1:0] base_page;
    logic [6:0] base_x;
    logic       first_r;
    logic       last_r;
    logic       row_end;
    logic       mb_end;
    logic [7:0] img_x;    // column relative to the start page origin
    logic [7:0] page_off;
    logic [7:0] tw_mask;

    assign row_end    = (col == mb_w_m1);
    assign mb_end     = row_end && (row == 4'(tile_rows - 1));
    assign img_x      = {1'b0, base_x} + {2'b0, col};
    assign tw_mask    = (8'd1 << tile_shift(tile_width)) - 8'd1;
    assign page_off   = img_x >> tile_shift(tile_width);
    assign rd_page    = base_page + page_off[1:0];
    assign rd_addr    = page_aw'({row, img_x[6:0] & tw_mask[6:0]});
    assign mb_pre_end = active && (row == 4'(tile_rows - 1)) && (col == mb_w_m1 - 6'd7);
    assign pix_data   = rd_data; // buffer output lines up with pix_valid

    always_ff @(posedge xclk) begin
        if (reset_page_rd) begin
            active       <= 1'b0;
            row          <= '0;
            col          <= '0;
            pix_valid    <= 1'b0;
            pix_first_mb <= 1'b0;
            pix_last_mb  <= 1'b0;
        end else begin
            pix_valid    <= active; // request delayed by the read latency
            pix_first_mb <= active && first_r;
            pix_last_mb  <= active && last_r;
            if (ctrl.mb_start) begin // may land on the last request, no gap
                active <= 1'b1;
                row    <= '0;
                col    <= '0;
            end else if (active) begin
                col <= row_end ? 6'd0 : col + 6'd1;
                if (row_end) row <= row + 4'd1;
                if (mb_end) active <= 1'b0;
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (ctrl.mb_start) begin
            base_page <= ctrl.start_page;
            base_x    <= ctrl.macroblock_x;
            first_r   <= ctrl.first_mb;
            last_r    <= ctrl.last_mb;
        end
    end

    a_no_cut_in: assert property (@(posedge xclk) disable iff (reset_page_rd)
        ctrl.mb_start |-> (!active || mb_end));

endmodule

`default_nettype wire

//--- rtl/cmprs_mb_sched.sv
// cmprs_mb_sched, top level of the macroblock scheduling front end
// page loader, tile buffer, macroblock pacer and pixel reader
`timescale 1ns/1ps
`default_nettype none

module cmprs_mb_sched #(
    parameter int data_w  = 8,
    parameter int page_aw = 11
) (
    input  wire logic               xclk,
    input  wire logic               reset_page_rd,
    input  wire logic               frame_en,
    input  wire logic               frame_go,
    input  wire cmprs_pkg::tile_w_e tile_width,
    input  wire logic [5:0]         mb_w_m1,
    input  wire logic [4:0]         mb_hper,
    input  wire logic [4:0]         left_marg,
    input  wire logic [12:0]        n_blocks_in_row_m1,
    input  wire logic [12:0]        n_block_rows_m1,
    input  wire logic               in_valid,
    input  wire logic [data_w-1:0]  in_data,
    output logic                    in_room,
    output logic                    pix_valid,
    output logic [data_w-1:0]       pix_data,
    output logic                    pix_first_mb,
    output logic                    pix_last_mb,
    output logic                    frame_done
);
    logic               page_ready;
    logic               release_pulse;
    logic [1:0]         release_cnt;
    logic               mb_pre_end;
    logic [1:0]         rd_page;
    logic [page_aw-1:0] rd_addr;
    logic [data_w-1:0]  rd_data;

    page_wr_if #(.data_w(data_w), .page_aw(page_aw)) wr_bus ();
    mb_ctrl_if ctrl_bus ();

    page_loader #(.data_w(data_w), .page_aw(page_aw)) u_loader (
        .xclk          (xclk),
        .reset_page_rd (reset_page_rd),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_room       (in_room),
        .tile_width    (tile_width),
        .release_pulse (release_pulse),
        .release_cnt   (release_cnt),
        .page_ready    (page_ready),
        .wr            (wr_bus.master)
    );

    tile_page_buf #(.data_w(data_w), .page_aw(page_aw)) u_buf (
        .xclk    (xclk),
        .wr      (wr_bus.slave),
        .rd_page (rd_page),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    mb_pacer u_pacer (
        .xclk               (xclk),
        .reset_page_rd      (reset_page_rd),
        .frame_en           (frame_en),
        .frame_go           (frame_go),
        .tile_width         (tile_width),
        .left_marg          (left_marg),
        .mb_w_m1            (mb_w_m1),
        .mb_hper            (mb_hper),
        .n_blocks_in_row_m1 (n_blocks_in_row_m1),
        .n_block_rows_m1    (n_block_rows_m1),
        .page_ready         (page_ready),
        .mb_pre_end         (mb_pre_end),
        .release_pulse      (release_pulse),
        .release_cnt        (release_cnt),
        .frame_done         (frame_done),
        .ctrl               (ctrl_bus.master)
    );

    mb_pixel_reader #(.data_w(data_w), .page_aw(page_aw)) u_reader (
        .xclk          (xclk),
        .reset_page_rd (reset_page_rd),
        .tile_width    (tile_width),
        .mb_w_m1       (mb_w_m1),
        .ctrl          (ctrl_bus.slave),
        .rd_page       (rd_page),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .mb_pre_end    (mb_pre_end),
        .pix_valid     (pix_valid),
        .pix_data      (pix_data),
        .pix_first_mb  (pix_first_mb),
        .pix_last_mb   (pix_last_mb)
    );

endmodule

`default_nettype wire

//--- dv/cmprs_mb_sched_tb.sv
// testbench of the macroblock scheduling front end
// frame settings table applied in a loop, random tile images pushed under back-pressure
// reference model of the macroblock pixel stream
// pixel, flag, count, in_room and frame_done checks
`timescale 1ns/1ps
`default_nettype none

module cmprs_mb_sched_tb;
    import cmprs_pkg::*;

    localparam int n_cases = 8;

    typedef struct packed {
        tile_w_e     tw;
        logic [5:0]  mb_w_m1;
        logic [4:0]  hper;
        logic [4:0]  marg;
        logic [12:0] cols_m1;
        logic [12:0] rows_m1;
        logic [15:0] n_pix;    // pixels the frame must deliver
    } case_t;

    logic        xclk = 1'b0;
    logic        reset_page_rd;
    logic        frame_en;
    logic        frame_go;
    tile_w_e     tile_width;
    logic [5:0]  mb_w_m1;
    logic [4:0]  mb_hper;
    logic [4:0]  left_marg;
    logic [12:0] n_blocks_in_row_m1;
    logic [12:0] n_block_rows_m1;
    logic        in_valid;
    pix_t        in_data;
    logic        in_room;
    logic        pix_valid;
    pix_t        pix_data;
    logic        pix_first_mb;
    logic        pix_last_mb;
    logic        frame_done;

    case_t      cases [n_cases];
    pix_t       img [$];           // tiles in load order, each one row by row
    logic [9:0] exp_q [$];         // first flag, last flag and pixel, in output order
    int         cycle_cnt = 0;
    int         cycle_limit = 2000; // grows with the bytes and pixels of every case
    int         k;

    cmprs_mb_sched UUT (.*);

    always #50 xclk = ~xclk;

    always @(posedge xclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: the frames did not finish within %0d clock cycles", cycle_limit);
            $display("Test failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at time %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "run stopped at the first mismatch");
        end
    endtask

    // one tile row must reach the rightmost column of the last macroblock in the row
    function automatic int tiles_per_row(input case_t c);
        return (int'(c.marg) + int'(c.cols_m1) * int'(c.hper) + int'(c.mb_w_m1))
               / (16 << int'(c.tw)) + 1;
    endfunction

    function automatic int frame_bytes(input case_t c);
        return tiles_per_row(c) * (int'(c.rows_m1) + 1) * (16 << int'(c.tw)) * tile_rows;
    endfunction

    // random image, then the expected stream by macroblock row, column, pixel row and column
    task automatic build_frame(input case_t c);
        int tw;
        int x;
        int tile;
        int r;
        int mb;
        int pr;
        int col;
        img.delete();
        exp_q.delete();
        tw = 16 << int'(c.tw);
        repeat (frame_bytes(c)) img.push_back(pix_t'($urandom));
        for (r = 0; r <= int'(c.rows_m1); r++) begin
            for (mb = 0; mb <= int'(c.cols_m1); mb++) begin
                for (pr = 0; pr < tile_rows; pr++) begin
                    for (col = 0; col <= int'(c.mb_w_m1); col++) begin
                        x    = mb * int'(c.hper) + int'(c.marg) + col; // x in the tile row
                        tile = r * tiles_per_row(c) + x / tw;
                        exp_q.push_back({(r == 0) && (mb == 0),
                                         (r == int'(c.rows_m1)) && (mb == int'(c.cols_m1)),
                                         img[tile * tw * tile_rows + pr * tw + x % tw]});
                    end
                end
            end
        end
    endtask

    // the source holds a byte until an edge sees in_valid and in_room together
    task automatic push_image();
        int idx;
        idx = 0;
        @(posedge xclk);
        in_valid <= 1'b1;
        in_data  <= img[0];
        while (idx < img.size()) begin
            @(posedge xclk);
            if (in_valid && in_room) idx++; // byte taken at this edge
            if (idx < img.size()) in_data <= img[idx];
            else in_valid <= 1'b0;
        end
    endtask

    task automatic run_frame(input int n_pix);
        int         got;
        logic       last_seen;   // previous cycle carried the last pixel of the frame
        logic       done;
        logic [9:0] exp;
        got       = 0;
        last_seen = 1'b0;
        done      = 1'b0;
        repeat (12) begin
            @(negedge xclk);
            check_equal(pix_valid, 0, "pix_valid high before the frame is enabled");
            check_equal(frame_done, 0, "frame_done high before the frame is enabled");
            check_equal(in_room, 1, "in_room low while the ring still has free pages");
        end
        @(posedge xclk);
        frame_en <= 1'b1;
        frame_go <= 1'b1;
        @(posedge xclk);
        frame_go <= 1'b0; // a single frame, no restart after the last macroblock
        while (!done) begin
            @(negedge xclk);
            if (frame_done) begin
                check_equal(last_seen, 1, "frame_done not one cycle after the last pixel");
                check_equal(got, n_pix, "pixel count at frame_done");
                done = 1'b1;
            end
            last_seen = 1'b0;
            if (pix_valid) begin
                check_equal(exp_q.size() != 0, 1, "pixel after the end of the frame");
                exp = exp_q.pop_front();
                check_equal(pix_data, exp[7:0], $sformatf("pixel %0d value", got));
                check_equal(pix_first_mb, exp[9], $sformatf("pixel %0d first_mb flag", got));
                check_equal(pix_last_mb, exp[8], $sformatf("pixel %0d last_mb flag", got));
                got++;
                last_seen = (exp_q.size() == 0);
            end
        end
    endtask

    initial begin
        reset_page_rd      = 1'b1;
        frame_en           = 1'b0;
        frame_go           = 1'b0;
        tile_width         = tw16;
        mb_w_m1            = '0;
        mb_hper            = '0;
        left_marg          = '0;
        n_blocks_in_row_m1 = '0;
        n_block_rows_m1    = '0;
        in_valid           = 1'b0;
        in_data            = '0;
        void'($urandom(7472));
        // tile width, mb_w_m1, hper, left_marg, columns-1, rows-1, pixels
        cases[0] = {tw16, 6'd15, 5'd16, 5'd0, 13'd2, 13'd1, 16'd1536};   // aligned
        cases[1] = {tw16, 6'd15, 5'd16, 5'd5, 13'd2, 13'd1, 16'd1536};   // two pages each
        cases[2] = {tw16, 6'd31, 5'd16, 5'd9, 13'd1, 13'd0, 16'd1024};   // three pages
        cases[3] = {tw16, 6'd15, 5'd8, 5'd0, 13'd6, 13'd1, 16'd3584};    // overlap, ring full
        cases[4] = {tw32, 6'd15, 5'd8, 5'd3, 13'd4, 13'd1, 16'd2560};    // overlap
        cases[5] = {tw32, 6'd31, 5'd31, 5'd31, 13'd2, 13'd2, 16'd4608};
        cases[6] = {tw64, 6'd15, 5'd20, 5'd7, 13'd3, 13'd1, 16'd2048};
        cases[7] = {tw128, 6'd15, 5'd24, 5'd11, 13'd5, 13'd2, 16'd4608};
        for (k = 0; k < n_cases; k++) begin
            cycle_limit += 4 * (frame_bytes(cases[k]) + int'(cases[k].n_pix));
        end
        for (k = 0; k < n_cases; k++) begin
            @(posedge xclk);
            reset_page_rd      <= 1'b1; // pointers and counters back to zero
            tile_width         <= cases[k].tw;
            mb_w_m1            <= cases[k].mb_w_m1;
            mb_hper            <= cases[k].hper;
            left_marg          <= cases[k].marg;
            n_blocks_in_row_m1 <= cases[k].cols_m1;
            n_block_rows_m1    <= cases[k].rows_m1;
            repeat (2) @(posedge xclk);
            reset_page_rd <= 1'b0;
            build_frame(cases[k]);
            fork
                push_image();
                run_frame(int'(cases[k].n_pix));
            join
            @(posedge xclk);
            frame_en <= 1'b0;
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- cmprs_mb_sched.f
common/cmprs_pkg.sv
common/cmprs_ifs.sv
rtl/page_loader.sv
tile_buf/tile_page_buf.sv
macroblock/mb_pacer.sv
macroblock/mb_pixel_reader.sv
rtl/cmprs_mb_sched.sv
dv/cmprs_mb_sched_tb.sv
